//--- testbench/fdc_stim.txt
# op addr value expected mask, hex. ops: 0 drive {wp,ready,side,size}, 1 write, 2 read compare
# 3 wait intrq, 4 read bytes (addr=side value=track expected=sector mask=count), 5 drq read, 6 {busy,intrq,drq}
0 0 10 0 0
2 1 0 00 ff
2 2 0 00 ff
2 0 0 00 01
1 1 5a 0 0
2 1 0 5a ff
1 2 07 0 0
2 2 0 07 ff
1 3 a5 0 0
2 3 0 a5 ff
0 0 00 0 0
2 0 0 90 90
0 0 10 0 0
1 0 00 0 0
3 0 0 0 0
2 1 0 00 ff
2 0 0 04 04
1 3 05 0 0
1 0 10 0 0
3 0 0 0 0
2 1 0 05 ff
2 0 0 00 04
1 0 50 0 0
3 0 0 0 0
2 1 0 06 ff
1 0 70 0 0
3 0 0 0 0
2 1 0 05 ff
# single sector reads on side 1
0 0 19 0 0
1 2 03 0 0
1 0 80 0 0
4 1 05 03 100
3 0 0 0 0
2 0 0 00 3c
0 0 1a 0 0
1 2 09 0 0
1 0 80 0 0
4 1 05 09 200
3 0 0 0 0
2 0 0 00 3c
# multi sector runs off the track
0 0 19 0 0
1 2 0f 0 0
1 0 90 0 0
4 1 05 0f 200
3 0 0 0 0
2 0 0 10 10
0 0 1a 0 0
1 2 0a 0 0
1 0 80 0 0
3 0 0 0 0
2 0 0 10 10
# read address twice
1 2 08 0 0
1 0 c0 0 0
5 3 0 05 ff
5 3 0 01 ff
5 3 0 08 ff
5 3 0 02 ff
5 3 0 00 ff
5 3 0 00 ff
3 0 0 0 0
1 0 c0 0 0
5 3 0 05 ff
5 3 0 01 ff
5 3 0 09 ff
5 3 0 02 ff
5 3 0 00 ff
5 3 0 00 ff
3 0 0 0 0
# lost data, force interrupt, write fault
1 0 c0 0 0
3 0 0 0 0
2 0 0 04 04
1 2 01 0 0
1 0 80 0 0
4 1 05 01 3
1 0 d0 0 0
3 0 0 0 0
6 0 0 02 06
1 0 a0 0 0
3 0 0 0 0
6 0 0 02 02
2 0 0 20 20
6 0 0 00 02

//--- flist.f
+incdir+common
common/fdc_pkg.sv
hw/fdc/fdc_host_port.sv
hw/fdc/fdc_geometry.sv
hw/fdc/fdc_timers.sv
hw/fdc/fdc_sequencer.sv
hw/fdc_top.sv
testbench/fdc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the floppy controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fdc_tb \
	-Mdir obj_dir -f flist.f

out=$(./obj_dir/Vfdc_tb) || true
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
	exit 0
else
	exit 1
fi

//--- testbench/fdc_tb.sv
// floppy controller testbench
`timescale 1ns/1ps
`default_nettype none

module fdc_tb;
	import fdc_pkg::*;

	logic             clk_sys;
	logic             rst;
	logic             io_en;
	logic             rd;
	logic             wr;
	reg_addr_t        addr;
	logic [7:0]       din;
	logic             wp;
	logic             ready;
	logic             side;
	logic [2:0]       size_code;
	logic [7:0]       dout;
	logic             drq;
	logic             intrq;
	logic             busy;
	logic [19:0]      buff_addr;
	logic             buff_read;
	logic [7:0]       buff_din;

	logic [31:0] rec_op[$];
	logic [31:0] rec_addr[$];
	logic [31:0] rec_value[$];
	logic [31:0] rec_exp[$];
	logic [31:0] rec_mask[$];
	int          cycles;
	int          cycle_limit;
	logic [19:0] seen_addr;   // image side, sampled with dout
	logic        seen_read;

	fdc_top dut (.*);

	// image RAM, one byte per address
	assign buff_din = buff_addr[7:0] ^ buff_addr[15:8];

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the controller stopped responding after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$fatal(1, "run aborted");
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "check mismatch");
		end
	endtask

	// ====================
	// host bus

	task automatic reg_write(input logic [1:0] a, input logic [7:0] v);
		@(posedge clk_sys);
		addr <= reg_addr_t'(a);
		din  <= v;
		wr   <= 1'b1;
		@(posedge clk_sys);
		wr <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic reg_read(input logic [1:0] a, output logic [7:0] v);
		@(posedge clk_sys);
		addr <= reg_addr_t'(a);
		rd   <= 1'b1;
		@(negedge clk_sys);
		v = dout;   // stable mid cycle
		seen_addr = buff_addr;
		seen_read = buff_read;
		@(posedge clk_sys);
		rd <= 1'b0;
		repeat (3) @(posedge clk_sys);   // let the falling edge side effects land
	endtask

	task automatic wait_drq_then_read(output logic [7:0] v);
		do @(negedge clk_sys); while (!drq);
		reg_read(A_DATA, v);
		@(negedge clk_sys);
		check_value("drq", {31'd0, drq}, 32'd0);   // byte taken
	endtask

	// ====================
	// image layout, track-side-sector order

	function automatic int spt_of(input logic [2:0] sc);
		case (sc)
			3'd1: return 16;
			3'd2: return 9;
			3'd3: return 5;
			3'd4: return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int bytes_of(input logic [2:0] sc);
		case (sc)
			3'd1: return 256;
			3'd2, 3'd4: return 512;
			3'd3: return 1024;
			default: return 128;
		endcase
	endfunction

	function automatic int image_addr_of(input logic [2:0] sc, input int trk,
		input int sd, input int sec, input int off);
		return ((trk * 2 + sd) * spt_of(sc) + sec - 1) * bytes_of(sc) + off;
	endfunction

	function automatic logic [7:0] image_byte_at(input int lin);
		return lin[7:0] ^ lin[15:8];
	endfunction

	task automatic read_sector_bytes(input int sd, input int trk, input int first,
		input int count);
		logic [7:0] got;
		int         nb;
		int         lin;
		nb = bytes_of(size_code);
		for (int i = 0; i < count; i++) begin
			lin = image_addr_of(size_code, trk, sd, first + i / nb, i % nb);
			wait_drq_then_read(got);
			check_value("buff_read", {31'd0, seen_read}, 32'd1);
			check_value("buff_addr", {12'd0, seen_addr}, lin);
			check_value("dout", got, image_byte_at(lin));
		end
	endtask

	// ====================
	// stimulus file

	task automatic load_records;
		int    fd;
		string line;
		logic [31:0] f[5];
		fd = $fopen("testbench/fdc_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file");
			$display("ERRORS FOUND");
			$fatal(1, "no stimulus");
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == "#") continue;
			if ($sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]) == 5) begin
				rec_op.push_back(f[0]);
				rec_addr.push_back(f[1]);
				rec_value.push_back(f[2]);
				rec_exp.push_back(f[3]);
				rec_mask.push_back(f[4]);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		logic [7:0] got;
		{rst, io_en, rd, wr, wp, ready, side} = 7'b1100000;
		addr = A_CMD_STATUS;
		din = 8'h00;
		size_code = 3'd0;
		cycles = 0;
		cycle_limit = 0;
		load_records();
		cycle_limit = rec_op.size() * 2000;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
		@(posedge clk_sys);
		foreach (rec_op[i]) begin
			case (rec_op[i])
				0: begin   // drive inputs
					@(posedge clk_sys);
					size_code <= rec_value[i][2:0];
					side      <= rec_value[i][3];
					ready     <= rec_value[i][4];
					wp        <= rec_value[i][5];
					repeat (2) @(posedge clk_sys);
				end
				1: reg_write(rec_addr[i][1:0], rec_value[i][7:0]);
				2: begin
					reg_read(rec_addr[i][1:0], got);
					check_value("dout", got & rec_mask[i][7:0], rec_exp[i][7:0] & rec_mask[i][7:0]);
				end
				3: begin
					do @(negedge clk_sys); while (!intrq);
				end
				4: read_sector_bytes(rec_addr[i], rec_value[i], rec_exp[i], rec_mask[i]);
				5: begin
					wait_drq_then_read(got);
					check_value("dout", got & rec_mask[i][7:0], rec_exp[i][7:0] & rec_mask[i][7:0]);
				end
				6: begin
					@(negedge clk_sys);
					check_value("busy_intrq_drq", {29'd0, busy, intrq, drq} & rec_mask[i],
						rec_exp[i] & rec_mask[i]);
				end
				default: begin
					$display("unknown operation %0d in the stimulus file", rec_op[i]);
					$display("ERRORS FOUND");
					$fatal(1, "bad stimulus");
				end
			endcase
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/fdc_top.sv
// floppy controller top
`timescale 1ns/1ps
`default_nettype none
`include "fdc_config.svh"

module fdc_top (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   io_en,
	input  logic                   rd,
	input  logic                   wr,
	input  fdc_pkg::reg_addr_t     addr,
	input  logic [7:0]             din,
	input  logic                   wp,
	input  logic                   ready,
	input  logic                   side,
	input  logic [2:0]             size_code,
	output logic [7:0]             dout,
	output logic                   drq,
	output logic                   intrq,
	output logic                   busy,
	output logic [`FDC_IMG_AW-1:0] buff_addr,
	output logic                   buff_read,
	input  logic [7:0]             buff_din
);
	import fdc_pkg::*;

	logic       cmd_wr;
	logic       track_wr;
	logic       sector_wr;
	logic       data_wr;
	logic       status_rd_done;
	logic       data_rd_done;
	logic [7:0] wr_data;
	logic       cmd_mode;
	logic       s_wrfault;
	logic       s_seekerr;
	logic       s_lostdata;
	logic       s_headloaded;
	logic       track0;
	logic       index;
	logic [7:0] disk_track;
	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] data_byte;
	logic [10:0] byte_offset;
	logic       sector_stream;
	logic       wdog_start;
	logic       wdog_bark;
	logic [7:0] sectors_per_track;
	size_code_t sector_size_code;
	fdc_state_t state;

	fdc_host_port u_host_port (.*);

	fdc_sequencer u_sequencer (.*);

	fdc_geometry u_geometry (
		.size_code         (size_code),
		.disk_track        (disk_track),
		.side              (side),
		.sector            (sector_reg),
		.byte_offset       (byte_offset),
		.buff_addr         (buff_addr),
		.sectors_per_track (sectors_per_track),
		.sector_size_code  (sector_size_code)
	);

	fdc_timers u_timers (.*);

	// drq comes from the sequencer but the host only sees it with busy in status
	a_drq_busy: assert property (@(posedge clk_sys) disable iff (rst) drq |-> busy);

	// geometry table only covers codes 0 to 4
	a_size_code: assert property (@(posedge clk_sys) disable iff (rst)
		(state != IDLE) |-> (size_code <= 3'd4));

endmodule

`default_nettype wire

//--- hw/fdc/fdc_sequencer.sv
// command sequencer
`timescale 1ns/1ps
`default_nettype none
`include "fdc_config.svh"

module fdc_sequencer (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                cmd_wr,
	input  logic                track_wr,
	input  logic                sector_wr,
	input  logic                data_wr,
	input  logic                status_rd_done,
	input  logic                data_rd_done,
	input  logic [7:0]          wr_data,
	input  logic                ready,
	input  logic                side,
	input  logic [7:0]          sectors_per_track,
	input  fdc_pkg::size_code_t sector_size_code,
	input  logic                wdog_bark,
	output logic                drq,
	output logic                busy,
	output logic                intrq,
	output logic                cmd_mode,
	output logic                s_wrfault,
	output logic                s_seekerr,
	output logic                s_lostdata,
	output logic                s_headloaded,
	output logic                track0,
	output logic [7:0]          disk_track,
	output logic [7:0]          track_reg,
	output logic [7:0]          sector_reg,
	output logic [7:0]          data_byte,
	output logic [10:0]         byte_offset,
	output logic                sector_stream,
	output logic                wdog_start,
	output fdc_pkg::fdc_state_t state
);
	import fdc_pkg::*;

	localparam logic [`FDC_DELAY_W-1:0] SEEK_LOAD = `FDC_SEEK_DELAY - 1;
	localparam logic [`FDC_DELAY_W-1:0] BYTE_LOAD = `FDC_BYTE_DELAY - 1;
	localparam logic [`FDC_DELAY_W-1:0] WAIT_LOAD = `FDC_WAIT_CYCLES - 1;

	logic [7:0]              data_reg;
	logic [7:0]              ra_sector;        // next id for read address
	logic [7:0]              ra_byte_sector;   // id sent by the current read address
	logic                    step_dir;         // 0 in, 1 out
	logic                    multi;
	logic                    rw_type;          // 1 read sector, 0 read address
	logic [10:0]             data_length;      // bytes left in this sector
	logic [`FDC_DELAY_W-1:0] delay_cnt;

	wire [3:0]  op           = wr_data[7:4];
	wire [10:0] sector_bytes = 11'd128 << sector_size_code;
	wire        dir_out      = wr_data[6] ? wr_data[5] : step_dir;
	wire [7:0]  next_track   = dir_out ? disk_track - 8'd1 : disk_track + 8'd1;
	wire        last_byte    = (data_length == 11'd1);
	wire        bad_sector   = (sector_reg == 8'd0) || (sector_reg > sectors_per_track);

	assign track0 = (disk_track == 8'd0);

	// id field of read address, then two crc bytes
	always_comb begin
		if (state == IDLE) begin
			data_byte = data_reg;
		end else begin
			case (byte_offset[2:0])
				3'd0:    data_byte = disk_track;
				3'd1:    data_byte = {7'd0, side};
				3'd2:    data_byte = ra_byte_sector;
				3'd3:    data_byte = {6'd0, sector_size_code};
				default: data_byte = 8'd0;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_wr) data_reg <= wr_data;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= IDLE;
			{drq, busy, intrq, cmd_mode} <= 4'b0000;
			{s_wrfault, s_seekerr, s_lostdata, s_headloaded} <= 4'b0000;
			disk_track <= 8'd0;
			track_reg <= 8'd0;
			sector_reg <= 8'd0;
			ra_sector <= 8'd1;
			step_dir <= 1'b0;
			multi <= 1'b0;
			rw_type <= 1'b0;
			sector_stream <= 1'b0;
			wdog_start <= 1'b0;
			byte_offset <= 11'd0;
			data_length <= 11'd0;
			delay_cnt <= '0;
		end else begin
			if (status_rd_done) intrq <= 1'b0;

			// ====================
			// transfer FSM
			case (state)
				IDLE: ;
				SEARCH: begin
					if (!ready) begin
						s_seekerr <= 1'b1;   // no disk
						state <= END;
					end else if (delay_cnt != '0) begin
						delay_cnt <= delay_cnt - 1'b1;
					end else if (rw_type && bad_sector) begin
						s_seekerr <= 1'b1;   // record not found
						state <= END;
					end else begin
						byte_offset <= 11'd0;
						data_length <= rw_type ? sector_bytes : 11'd6;
						delay_cnt <= BYTE_LOAD;
						wdog_start <= 1'b1;
						state <= READ_PREP;
					end
				end
				READ_PREP: begin
					if (delay_cnt != '0) begin
						delay_cnt <= delay_cnt - 1'b1;
					end else begin
						wdog_start <= 1'b0;
						drq <= 1'b1;
						state <= READ_WAIT;
					end
				end
				READ_WAIT: begin
					if (wdog_bark || data_rd_done) begin
						drq <= 1'b0;
						if (wdog_bark) s_lostdata <= 1'b1;   // byte skipped
						if (!last_byte) begin
							byte_offset <= byte_offset + 11'd1;
							data_length <= data_length - 11'd1;
							delay_cnt <= BYTE_LOAD;
							wdog_start <= 1'b1;
							state <= READ_PREP;
						end else if (multi) begin
							sector_reg <= sector_reg + 8'd1;   // runs off the track with seek error
							delay_cnt <= SEEK_LOAD;
							state <= SEARCH;
						end else begin
							state <= END;
						end
					end
				end
				WAIT: begin
					if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;
					else state <= END;
				end
				ABORT: begin
					{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
					state <= END;
				end
				default: begin   // END
					drq <= 1'b0;
					busy <= 1'b0;
					intrq <= 1'b1;
					sector_stream <= 1'b0;
					wdog_start <= 1'b0;
					state <= IDLE;
				end
			endcase

			// ====================
			// register writes
			if (track_wr && !busy) track_reg <= wr_data;
			if (sector_wr && !busy) begin
				sector_reg <= wr_data;
				ra_sector <= wr_data;
			end

			if (cmd_wr) begin
				intrq <= 1'b0;
				if (state == IDLE || op == 4'hD) begin
					if (!wr_data[7]) begin
						// type I
						cmd_mode <= 1'b0;
						s_headloaded <= wr_data[3];
						s_seekerr <= 1'b0;
						busy <= 1'b1;
						delay_cnt <= WAIT_LOAD;
						state <= WAIT;
						if (op == 4'h0) begin
							track_reg <= 8'd0;
							disk_track <= 8'd0;
						end else if (op == 4'h1) begin
							track_reg <= data_reg;   // seek target
							disk_track <= data_reg;
						end else begin
							if (wr_data[6]) step_dir <= wr_data[5];
							disk_track <= next_track;
							if (wr_data[4]) track_reg <= next_track;
						end
					end else begin
						case (op)
							4'h8, 4'h9: begin
								cmd_mode <= 1'b1;
								{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
								busy <= 1'b1;
								multi <= wr_data[4];
								rw_type <= 1'b1;
								sector_stream <= 1'b1;
								delay_cnt <= SEEK_LOAD;
								state <= SEARCH;
							end
							4'hA, 4'hB: begin
								cmd_mode <= 1'b1;
								{s_seekerr, s_lostdata} <= 2'b00;
								s_wrfault <= 1'b1;   // read-only image
								busy <= 1'b1;
								delay_cnt <= WAIT_LOAD;
								state <= WAIT;
							end
							4'hC: begin
								cmd_mode <= 1'b1;
								{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
								busy <= 1'b1;
								multi <= 1'b0;
								rw_type <= 1'b0;
								ra_byte_sector <= ra_sector;
								if (ra_sector >= sectors_per_track) ra_sector <= 8'd1;
								else ra_sector <= ra_sector + 8'd1;
								delay_cnt <= SEEK_LOAD;
								state <= SEARCH;
							end
							4'hD: begin
								cmd_mode <= 1'b0;
								if (state != IDLE) begin
									state <= ABORT;
								end else begin
									{s_wrfault, s_seekerr, s_lostdata} <= 3'b000;
									{drq, busy} <= 2'b00;
								end
							end
							default: ;   // track commands ignored
						endcase
					end
				end
			end
		end
	end

	a_intrq_busy: assert property (@(posedge clk_sys) disable iff (rst) !(intrq && busy));

endmodule

`default_nettype wire

//--- hw/fdc/fdc_timers.sv
// index pulse and data watchdog
`timescale 1ns/1ps
`default_nettype none
`include "fdc_config.svh"

module fdc_timers (
	input  logic clk_sys,
	input  logic rst,
	input  logic ready,
	input  logic wdog_start,
	output logic index,
	output logic wdog_bark
);
	localparam int IDX_W  = $clog2(`FDC_INDEX_PERIOD);
	localparam int WDOG_W = $clog2(`FDC_WDOG_CYCLES + 1);

	localparam logic [IDX_W-1:0]  IDX_LAST  = `FDC_INDEX_PERIOD - 1;
	localparam logic [IDX_W-1:0]  IDX_HIGH  = `FDC_INDEX_WIDTH;
	localparam logic [WDOG_W-1:0] WDOG_LOAD = `FDC_WDOG_CYCLES;

	logic [IDX_W-1:0]  idx_cnt;
	logic [WDOG_W-1:0] wdog_cnt;

	// ====================
	// one revolution per period

	always_ff @(posedge clk_sys) begin
		if (rst || !ready) begin
			idx_cnt <= '0;   // disk stopped
		end else if (idx_cnt == IDX_LAST) begin
			idx_cnt <= '0;
		end else begin
			idx_cnt <= idx_cnt + 1'b1;
		end
	end

	assign index = ready && (idx_cnt < IDX_HIGH);

	// ====================
	// lost data watchdog

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wdog_cnt <= '0;
		end else if (wdog_start) begin
			wdog_cnt <= WDOG_LOAD;   // held while the byte is prepared
		end else if (wdog_cnt != '0) begin
			wdog_cnt <= wdog_cnt - 1'b1;
		end
	end

	assign wdog_bark = (wdog_cnt == '0);

	a_bark_start: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(wdog_bark) |-> !wdog_start);

endmodule

`default_nettype wire

//--- hw/fdc/fdc_geometry.sv
// disk image geometry
`timescale 1ns/1ps
`default_nettype none
`include "fdc_config.svh"

module fdc_geometry (
	input  logic [2:0]             size_code,
	input  logic [7:0]             disk_track,
	input  logic                   side,
	input  logic [7:0]             sector,
	input  logic [10:0]            byte_offset,
	output logic [`FDC_IMG_AW-1:0] buff_addr,
	output logic [7:0]             sectors_per_track,
	output fdc_pkg::size_code_t    sector_size_code
);
	logic [8:0]             log_track;    // track-side order
	logic [16:0]            sector_num;   // linear sector index in the image
	logic [`FDC_IMG_AW-1:0] sector_base;

	// track formats, all fixed
	always_comb begin
		case (size_code)
			3'd0:    sectors_per_track = 8'd26;   // 26 x 128
			3'd1:    sectors_per_track = 8'd16;   // 16 x 256
			3'd2:    sectors_per_track = 8'd9;    // 9 x 512
			3'd3:    sectors_per_track = 8'd5;    // 5 x 1024
			3'd4:    sectors_per_track = 8'd10;   // 10 x 512
			default: sectors_per_track = 8'd26;
		endcase
	end

	always_comb begin
		case (size_code)
			3'd1:    sector_size_code = 2'd1;
			3'd2:    sector_size_code = 2'd2;
			3'd3:    sector_size_code = 2'd3;
			3'd4:    sector_size_code = 2'd2;
			default: sector_size_code = 2'd0;
		endcase
	end

	// sectors count from 1
	assign log_track   = {disk_track, side};
	assign sector_num  = 17'(log_track) * 17'(sectors_per_track) + 17'(sector) - 17'd1;
	assign sector_base = `FDC_IMG_AW'(sector_num) << (4'd7 + 4'(sector_size_code));
	assign buff_addr   = sector_base + `FDC_IMG_AW'(byte_offset);

endmodule

`default_nettype wire

//--- hw/fdc/fdc_host_port.sv
// host register port
`timescale 1ns/1ps
`default_nettype none

module fdc_host_port (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               io_en,
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::reg_addr_t addr,
	input  logic [7:0]         din,
	output logic               cmd_wr,
	output logic               track_wr,
	output logic               sector_wr,
	output logic               data_wr,
	output logic               status_rd_done,
	output logic               data_rd_done,
	output logic [7:0]         wr_data,
	input  logic               cmd_mode,
	input  logic               busy,
	input  logic               drq,
	input  logic               s_wrfault,
	input  logic               s_seekerr,
	input  logic               s_lostdata,
	input  logic               s_headloaded,
	input  logic               track0,
	input  logic               index,
	input  logic               ready,
	input  logic               wp,
	input  logic [7:0]         track_reg,
	input  logic [7:0]         sector_reg,
	input  logic [7:0]         data_byte,
	input  logic               sector_stream,
	input  logic [7:0]         buff_din,
	output logic [7:0]         dout,
	output logic               buff_read
);
	import fdc_pkg::*;

	logic       old_rd;
	logic       old_wr;
	reg_addr_t  cur_addr;   // address of the access in progress
	logic [7:0] status;

	wire rde       = rd & io_en;
	wire wre       = wr & io_en;
	wire rd_rise   = rde & ~old_rd;
	wire rd_fall   = ~rde & old_rd;
	wire wr_rise   = wre & ~old_wr;

	// ====================
	// strobe edges to pulses

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
			cur_addr <= A_CMD_STATUS;
			{cmd_wr, track_wr, sector_wr, data_wr} <= 4'b0000;
			{status_rd_done, data_rd_done} <= 2'b00;
		end else begin
			old_rd <= rde;
			old_wr <= wre;
			if (rd_rise || wr_rise) cur_addr <= addr;
			cmd_wr    <= wr_rise && (addr == A_CMD_STATUS);
			track_wr  <= wr_rise && (addr == A_TRACK);
			sector_wr <= wr_rise && (addr == A_SECTOR);
			data_wr   <= wr_rise && (addr == A_DATA);
			status_rd_done <= rd_fall && (cur_addr == A_CMD_STATUS);   // clears intrq
			data_rd_done   <= rd_fall && (cur_addr == A_DATA);         // byte consumed
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise) wr_data <= din;
	end

	// ====================
	// status and read mux

	always_comb begin
		if (!cmd_mode) begin
			status = {~ready, 1'b1, s_headloaded, s_seekerr | ~ready,   // image never writable
				1'b0, track0, index, busy};
		end else begin
			status = {~ready, 1'b1, s_wrfault, s_seekerr | ~ready,
				1'b0, s_lostdata, drq, busy};
		end
	end

	always_comb begin
		case (addr)
			A_CMD_STATUS: dout = status;
			A_TRACK:      dout = track_reg;
			A_SECTOR:     dout = sector_reg;
			default:      dout = sector_stream ? buff_din : data_byte;
		endcase
	end

	assign buff_read = sector_stream && (addr == A_DATA);

	// at most one register event per cycle
	a_pulse_onehot: assert property (@(posedge clk_sys) disable iff (rst)
		$onehot0({cmd_wr, track_wr, sector_wr, data_wr, status_rd_done, data_rd_done}));

endmodule

`default_nettype wire

//--- common/fdc_pkg.sv
// floppy controller types
`default_nettype none

package fdc_pkg;

	// host register map, status and command share address 0
	typedef enum logic [1:0] {
		A_CMD_STATUS = 2'd0,
		A_TRACK      = 2'd1,
		A_SECTOR     = 2'd2,
		A_DATA       = 2'd3
	} reg_addr_t;

	// ====================
	// sequencer states

	typedef enum logic [2:0] {
		IDLE,
		SEARCH,     // seek delay, sector id check
		READ_PREP,  // byte preparation delay
		READ_WAIT,  // drq up, waiting on host or watchdog
		WAIT,       // fixed busy time
		ABORT,
		END
	} fdc_state_t;

	// bytes per sector = 128 << code
	typedef logic [1:0] size_code_t;

endpackage

`default_nettype wire

//--- common/fdc_config.svh
// floppy controller constants
`ifndef FDC_CONFIG_SVH
`define FDC_CONFIG_SVH

// image address width, 1 MB max
`define FDC_IMG_AW 20

// width of the shared delay counter in the sequencer
`define FDC_DELAY_W 8

// cycles spent in search before the first byte
`define FDC_SEEK_DELAY 16

// cycles to prepare each byte before drq
`define FDC_BYTE_DELAY 16

// busy time of type I and faulted commands
`define FDC_WAIT_CYCLES 40

// cycles with drq up before the byte counts as lost
`define FDC_WDOG_CYCLES 256

// index pulse shape
`define FDC_INDEX_PERIOD 350
`define FDC_INDEX_WIDTH 4

`endif
